/* csr_unit.f */
+incdir+include
rtl/csr_pkg.sv
rtl/csr_counter64.sv
rtl/csr_time_base.sv
rtl/csr_access.sv
rtl/csr_unit.sv
tests/csr_unit_tb.sv

/* include/csr_unit_tb_tasks.svh */
`ifndef CSR_UNIT_TB_TASKS_SVH
`define CSR_UNIT_TB_TASKS_SVH

task automatic report_mismatch(input string name, input csr_pkg::csr_word_t expected,
                               input csr_pkg::csr_word_t actual);
    mismatch_count++;
    $display("Error %s: expected %h, actual %h", name, expected, actual);
endtask

// Fixed idle time, inputs stay 2 ns past the edge
task automatic idle_cycles(input int n);
    repeat (n) begin
        @(posedge clk);
        #2;
    end
endtask

// One request strobe, then wait for the response
task automatic issue_access(input csr_pkg::csr_op_e a_op, input csr_pkg::csr_addr_t a_addr,
                            input csr_pkg::csr_word_t a_operand,
                            output csr_pkg::csr_word_t a_rdata, output logic a_illegal);
    int waited;
    waited  = 0;
    req     = 1'b1;
    op      = a_op;
    addr    = a_addr;
    operand = a_operand;
    @(posedge clk);  // Sampling edge, write lands here
    #2;
    req = 1'b0;
    while (!rsp && waited < 10) begin
        @(posedge clk);
        #2;
        waited++;
    end
    if (!rsp) begin
        timeout_count++;
        $display("Timeout: no response to the access at address %h", a_addr);
        a_rdata   = 'x;
        a_illegal = 1'bx;
    end else begin
        a_rdata   = rsp_data;
        a_illegal = rsp_illegal;
    end
endtask

// Set with zero source, a pure read
task automatic read_csr(input csr_pkg::csr_addr_t a_addr, output csr_pkg::csr_word_t data);
    logic ill;
    issue_access(csr_pkg::RS, a_addr, 32'h0, data, ill);
endtask

task automatic check_read(input string name, input csr_pkg::csr_addr_t a_addr,
                          input csr_pkg::csr_word_t expected);
    csr_pkg::csr_word_t rd;
    logic               ill;
    issue_access(csr_pkg::RS, a_addr, 32'h0, rd, ill);
    if (ill !== 1'b0) report_mismatch(name, 32'h0, ill);  // Legal address
    if (rd !== expected) report_mismatch(name, expected, rd);
endtask

task automatic test_cycle_rw();
    csr_pkg::csr_word_t v;
    csr_pkg::csr_word_t h;
    csr_pkg::csr_word_t rd;
    logic               ill;
    v = next_random() & 32'h7FFF_FFFF;  // No carry into cycleh during the test
    h = next_random();
    issue_access(csr_pkg::RW, csr_pkg::CYCLE_ADDR, v, rd, ill);
    check_read("test_cycle_rw", csr_pkg::CYCLE_ADDR, v);  // No increment on the write edge
    idle_cycles(5);
    check_read("test_cycle_rw", csr_pkg::CYCLE_ADDR, v + 6);
    issue_access(csr_pkg::RW, csr_pkg::CYCLEH_ADDR, h, rd, ill);  // Low half held at v+7
    check_read("test_cycle_rw", csr_pkg::CYCLEH_ADDR, h);
    check_read("test_cycle_rw", csr_pkg::CYCLE_ADDR, v + 8);
endtask

task automatic test_set_clear();
    csr_pkg::csr_word_t w;
    csr_pkg::csr_word_t m;
    csr_pkg::csr_word_t c;
    csr_pkg::csr_word_t rd;
    logic               ill;
    w = next_random();
    m = next_random();
    c = next_random();
    issue_access(csr_pkg::RW, csr_pkg::INSTRETH_ADDR, w, rd, ill);
    issue_access(csr_pkg::RS, csr_pkg::INSTRETH_ADDR, m, rd, ill);
    if (rd !== w) report_mismatch("test_set_clear", w, rd);  // Old value returned
    check_read("test_set_clear", csr_pkg::INSTRETH_ADDR, w | m);
    issue_access(csr_pkg::RC, csr_pkg::INSTRETH_ADDR, c, rd, ill);
    if (rd !== (w | m)) report_mismatch("test_set_clear", w | m, rd);
    check_read("test_set_clear", csr_pkg::INSTRETH_ADDR, (w | m) & ~c);
endtask

task automatic test_immediate();
    csr_pkg::csr_word_t a;
    csr_pkg::csr_word_t exp;
    csr_pkg::csr_word_t rd;
    logic               ill;
    a   = next_random() | 32'hFFFF_FF00;  // Upper bits set, must be dropped
    exp = a & 32'h1F;
    issue_access(csr_pkg::RWI, csr_pkg::INSTRET_ADDR, a, rd, ill);
    check_read("test_immediate", csr_pkg::INSTRET_ADDR, exp);
    a   = next_random() | 32'h8000_0000;
    exp = exp | (a & 32'h1F);
    issue_access(csr_pkg::RSI, csr_pkg::INSTRET_ADDR, a, rd, ill);
    check_read("test_immediate", csr_pkg::INSTRET_ADDR, exp);
    a   = next_random() | 32'h8000_0000;
    exp = exp & ~(a & 32'h1F);
    issue_access(csr_pkg::RCI, csr_pkg::INSTRET_ADDR, a, rd, ill);
    check_read("test_immediate", csr_pkg::INSTRET_ADDR, exp);
    issue_access(csr_pkg::RSI, csr_pkg::INSTRET_ADDR, 32'hFFFF_FFE0, rd, ill);  // Zero imm
    check_read("test_immediate", csr_pkg::INSTRET_ADDR, exp);
endtask

task automatic test_instret_count();
    csr_pkg::csr_word_t rd;
    csr_pkg::csr_word_t r;
    logic               ill;
    int                 n;
    n = 0;
    issue_access(csr_pkg::RW, csr_pkg::INSTRET_ADDR, 32'h0, rd, ill);
    for (int i = 0; i < 24; i++) begin
        r      = next_random();
        retire = r[16];  // Retires spread among idle cycles
        if (retire) n++;
        @(posedge clk);
        #2;
    end
    retire = 1'b0;
    check_read("test_instret_count", csr_pkg::INSTRET_ADDR, n);
endtask

task automatic test_time_tick();
    csr_pkg::csr_word_t c0;
    csr_pkg::csr_word_t c1;
    csr_pkg::csr_word_t t;
    csr_pkg::csr_word_t rd;
    logic               ill;
    read_csr(csr_pkg::CYCLE_ADDR, c0);
    issue_access(csr_pkg::RW, csr_pkg::TIME_ADDR, 32'h0, rd, ill);
    idle_cycles(40);  // 40 edges hold 40/TIME_DIV ticks
    read_csr(csr_pkg::TIME_ADDR, t);
    read_csr(csr_pkg::CYCLE_ADDR, c1);
    if (t < 9 || t > 10) begin
        mismatch_count++;
        $display("Error test_time_tick: expected 9 to 10, actual %0d", t);
    end
    if (t >= c1 - c0) begin
        mismatch_count++;
        $display("Error test_time_tick: expected below %0d, actual %0d", c1 - c0, t);
    end
endtask

task automatic test_illegal();
    csr_pkg::csr_word_t c0;
    csr_pkg::csr_word_t rd;
    logic               ill;
    read_csr(csr_pkg::CYCLE_ADDR, c0);
    issue_access(csr_pkg::RW, 12'h300, next_random(), rd, ill);  // Machine CSR, not here
    if (ill !== 1'b1) report_mismatch("test_illegal", 32'h1, ill);
    issue_access(csr_pkg::csr_op_e'(3'd4), csr_pkg::CYCLE_ADDR, 32'hFFFF_FFFF, rd, ill);
    if (ill !== 1'b1) report_mismatch("test_illegal", 32'h1, ill);
    check_read("test_illegal", csr_pkg::CYCLE_ADDR, c0 + 3);  // Counted on, never written
endtask

`endif

/* tests/csr_unit_tb.sv */
`timescale 1ns/100ps

module csr_unit_tb;

    localparam int unsigned TIME_DIV = 4;  // Short tick period for the time test

    logic                clk;
    logic                rst_n;
    logic                req;
    csr_pkg::csr_op_e    op;
    csr_pkg::csr_addr_t  addr;
    csr_pkg::csr_word_t  operand;
    logic                retire;
    logic                rsp;
    logic                rsp_illegal;
    csr_pkg::csr_word_t  rsp_data;

    int                  mismatch_count;
    int                  timeout_count;
    logic [31:0]         lcg_state;

    // Numerical Recipes constants, full period mod 2^32
    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;  // 40 ns period
    end

    csr_unit #(
        .TIME_DIV (TIME_DIV)
    ) UUT (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_req_i     (req),
        .csr_op_i      (op),
        .csr_addr_i    (addr),
        .csr_operand_i (operand),
        .retire_i      (retire),
        .csr_rsp_o     (rsp),
        .csr_illegal_o (rsp_illegal),
        .csr_rdata_o   (rsp_data)
    );

    `include "csr_unit_tb_tasks.svh"

    initial begin
        mismatch_count = 0;
        timeout_count  = 0;
        lcg_state      = 32'd54;
        rst_n          = 1'b0;
        req            = 1'b0;
        op             = csr_pkg::NONE;
        addr           = '0;
        operand        = '0;
        retire         = 1'b0;
        repeat (3) @(posedge clk);  // Three cycles in reset
        #2;
        rst_n = 1'b1;

        test_cycle_rw();
        test_set_clear();
        test_immediate();
        test_instret_count();
        test_time_tick();
        test_illegal();

        $display("Mismatches: %0d, timeouts: %0d", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* rtl/csr_unit.sv */
`timescale 1ns/100ps

module csr_unit #(
    parameter int unsigned TIME_DIV = 10  // Clocks per time tick
) (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                csr_req_i,      // One-cycle strobe
    input  csr_pkg::csr_op_e    csr_op_i,
    input  csr_pkg::csr_addr_t  csr_addr_i,
    input  csr_pkg::csr_word_t  csr_operand_i,
    input  logic                retire_i,       // One instruction retired
    output logic                csr_rsp_o,
    output logic                csr_illegal_o,
    output csr_pkg::csr_word_t  csr_rdata_o
);

    csr_pkg::csr_dword_t cycle_val;
    csr_pkg::csr_dword_t time_val;
    csr_pkg::csr_dword_t instret_val;
    logic                cycle_wr;
    logic                time_wr;
    logic                instret_wr;
    logic                wr_hi;
    csr_pkg::csr_word_t  wr_data;
    logic                tick;

    // Decode, read-modify-write and response
    csr_access u_access (
        .clk           (clk),
        .rst_n         (rst_n),
        .csr_req_i     (csr_req_i),
        .csr_op_i      (csr_op_i),
        .csr_addr_i    (csr_addr_i),
        .csr_operand_i (csr_operand_i),
        .cycle_i       (cycle_val),
        .time_i        (time_val),
        .instret_i     (instret_val),
        .cycle_wr_o    (cycle_wr),
        .time_wr_o     (time_wr),
        .instret_wr_o  (instret_wr),
        .wr_hi_o       (wr_hi),
        .wr_data_o     (wr_data),
        .csr_rsp_o     (csr_rsp_o),
        .csr_illegal_o (csr_illegal_o),
        .csr_rdata_o   (csr_rdata_o)
    );

    // Real-time source for the time CSR
    csr_time_base #(
        .TIME_DIV (TIME_DIV)
    ) u_time_base (
        .clk    (clk),
        .rst_n  (rst_n),
        .tick_o (tick)
    );

    csr_counter64 u_cycle (
        .clk       (clk),
        .rst_n     (rst_n),
        .inc_i     (1'b1),      // Every clock
        .wr_i      (cycle_wr),
        .wr_hi_i   (wr_hi),
        .wr_data_i (wr_data),
        .value_o   (cycle_val)
    );

    csr_counter64 u_time (
        .clk       (clk),
        .rst_n     (rst_n),
        .inc_i     (tick),
        .wr_i      (time_wr),
        .wr_hi_i   (wr_hi),
        .wr_data_i (wr_data),
        .value_o   (time_val)
    );

    csr_counter64 u_instret (
        .clk       (clk),
        .rst_n     (rst_n),
        .inc_i     (retire_i),
        .wr_i      (instret_wr),
        .wr_hi_i   (wr_hi),
        .wr_data_i (wr_data),
        .value_o   (instret_val)
    );

endmodule

/* rtl/csr_access.sv */
`timescale 1ns/100ps

module csr_access (
    input  logic                clk,
    input  logic                rst_n,
    // Request from the core
    input  logic                csr_req_i,
    input  csr_pkg::csr_op_e    csr_op_i,
    input  csr_pkg::csr_addr_t  csr_addr_i,
    input  csr_pkg::csr_word_t  csr_operand_i,
    // Current counter values
    input  csr_pkg::csr_dword_t cycle_i,
    input  csr_pkg::csr_dword_t time_i,
    input  csr_pkg::csr_dword_t instret_i,
    // Write port, shared by the three counters
    output logic                cycle_wr_o,
    output logic                time_wr_o,
    output logic                instret_wr_o,
    output logic                wr_hi_o,
    output csr_pkg::csr_word_t  wr_data_o,
    // Response, one clock after the request
    output logic                csr_rsp_o,
    output logic                csr_illegal_o,
    output csr_pkg::csr_word_t  csr_rdata_o
);

    csr_pkg::csr_sel_e  sel;        // Addressed counter
    logic               sel_hi;     // Upper half
    logic               addr_ok;
    logic               illegal;
    logic               do_write;
    csr_pkg::csr_dword_t sel_val;
    csr_pkg::csr_word_t old_half;   // Value before the access
    csr_pkg::csr_word_t src;        // Operand after immediate rule

    logic               rsp_q;
    logic               illegal_q;
    csr_pkg::csr_word_t rdata_q;

    // Address decode
    always_comb begin
        sel     = csr_pkg::SEL_CYCLE;
        sel_hi  = 1'b0;
        addr_ok = 1'b1;
        case (csr_addr_i)
            csr_pkg::CYCLE_ADDR: begin
                sel = csr_pkg::SEL_CYCLE;
            end
            csr_pkg::CYCLEH_ADDR: begin
                sel    = csr_pkg::SEL_CYCLE;
                sel_hi = 1'b1;
            end
            csr_pkg::TIME_ADDR: begin
                sel = csr_pkg::SEL_TIME;
            end
            csr_pkg::TIMEH_ADDR: begin
                sel    = csr_pkg::SEL_TIME;
                sel_hi = 1'b1;
            end
            csr_pkg::INSTRET_ADDR: begin
                sel = csr_pkg::SEL_INSTRET;
            end
            csr_pkg::INSTRETH_ADDR: begin
                sel    = csr_pkg::SEL_INSTRET;
                sel_hi = 1'b1;
            end
            default: begin
                addr_ok = 1'b0;  // Not a counter CSR
            end
        endcase
    end

    // Bad address or the unused op encoding
    assign illegal = !addr_ok || !csr_pkg::op_legal(csr_op_i);

    // Old value of the addressed half
    always_comb begin
        case (sel)
            csr_pkg::SEL_CYCLE:   sel_val = cycle_i;
            csr_pkg::SEL_TIME:    sel_val = time_i;
            csr_pkg::SEL_INSTRET: sel_val = instret_i;
            default:              sel_val = '0;
        endcase
        old_half = sel_hi ? sel_val[63:32] : sel_val[31:0];
    end

    assign src      = csr_pkg::op_operand(csr_op_i, csr_operand_i);
    assign do_write = csr_req_i && !illegal && csr_pkg::op_writes(csr_op_i, src);

    // Write lands on the edge that samples the request
    assign wr_data_o    = csr_pkg::op_apply(csr_op_i, old_half, src);
    assign wr_hi_o      = sel_hi;
    assign cycle_wr_o   = do_write && (sel == csr_pkg::SEL_CYCLE);
    assign time_wr_o    = do_write && (sel == csr_pkg::SEL_TIME);
    assign instret_wr_o = do_write && (sel == csr_pkg::SEL_INSTRET);

    // Response register
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rsp_q     <= 1'b0;
            illegal_q <= 1'b0;
            rdata_q   <= '0;
        end else begin
            rsp_q     <= csr_req_i;
            illegal_q <= csr_req_i && illegal;
            if (csr_req_i) begin
                rdata_q <= illegal ? '0 : old_half;  // Nothing returned on a fault
            end
        end
    end

    assign csr_rsp_o     = rsp_q;
    assign csr_illegal_o = illegal_q;
    assign csr_rdata_o   = rdata_q;

    // Every request answered on the next edge
    a_rsp_follows_req: assert property (
        @(posedge clk) disable iff (!rst_n)
        csr_req_i |=> csr_rsp_o
    ) else $error("request without response");

    // Fault flag only travels with a response
    a_illegal_with_rsp: assert property (
        @(posedge clk) disable iff (!rst_n)
        csr_illegal_o |-> csr_rsp_o
    ) else $error("illegal flag without response");

    // Illegal access leaves every counter alone
    a_no_write_illegal: assert property (
        @(posedge clk) disable iff (!rst_n)
        (csr_req_i && illegal) |-> !(cycle_wr_o || time_wr_o || instret_wr_o)
    ) else $error("write enable on illegal access");

endmodule

/* rtl/csr_time_base.sv */
`timescale 1ns/100ps

module csr_time_base #(
    parameter int unsigned TIME_DIV = 10  // Tick period in clocks, 1 or more
) (
    input  logic clk,
    input  logic rst_n,
    output logic tick_o
);

    // At least one bit, also for TIME_DIV of 1
    localparam int unsigned CNT_W = (TIME_DIV > 1) ? $clog2(TIME_DIV) : 1;
    localparam logic [CNT_W-1:0] RELOAD = CNT_W'(TIME_DIV - 1);

    logic [CNT_W-1:0] cnt_q;
    logic             tick_q;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q  <= RELOAD;  // Full period before first tick
            tick_q <= 1'b0;
        end else begin
            tick_q <= (cnt_q == '0);
            if (cnt_q == '0) begin
                cnt_q <= RELOAD;  // Wrap
            end else begin
                cnt_q <= cnt_q - 1'b1;
            end
        end
    end

    assign tick_o = tick_q;

    // Single-cycle pulse unless dividing by one
    a_tick_pulse: assert property (
        @(posedge clk) disable iff (!rst_n)
        (TIME_DIV > 1) && tick_o |=> !tick_o
    ) else $error("time tick held for two cycles");

endmodule

/* rtl/csr_counter64.sv */
`timescale 1ns/100ps

module csr_counter64 (
    input  logic                clk,
    input  logic                rst_n,
    input  logic                inc_i,      // Count enable
    input  logic                wr_i,       // Half-word write strobe
    input  logic                wr_hi_i,    // 1 selects bits 63:32
    input  csr_pkg::csr_word_t  wr_data_i,
    output csr_pkg::csr_dword_t value_o
);

    csr_pkg::csr_dword_t cnt_q;
    csr_pkg::csr_dword_t cnt_d;

    // Next value
    always_comb begin
        cnt_d = cnt_q;
        if (wr_i) begin
            // Write wins and freezes the other half for this cycle
            if (wr_hi_i) begin
                cnt_d[63:32] = wr_data_i;
            end else begin
                cnt_d[31:0] = wr_data_i;
            end
        end else if (inc_i) begin
            cnt_d = cnt_q + 64'd1;  // Carry runs through both halves
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cnt_q <= '0;
        end else begin
            cnt_q <= cnt_d;
        end
    end

    assign value_o = cnt_q;  // Read straight off the register

    // Without a write the step is 0 or 1 even across a wrap
    a_step_max_one: assert property (
        @(posedge clk) disable iff (!rst_n)
        !wr_i |=> (cnt_q - $past(cnt_q)) <= 64'd1
    ) else $error("counter jumped by more than one");

endmodule

/* rtl/csr_pkg.sv */
package csr_pkg;

    // Widths with a meaning
    typedef logic [11:0] csr_addr_t;   // CSR address space
    typedef logic [31:0] csr_word_t;   // Register width, operand and read data
    typedef logic [63:0] csr_dword_t;  // Full counter

    // Operation, same encoding as funct3 of the SYSTEM opcode
    typedef enum logic [2:0] {
        NONE = 3'd0,
        RW   = 3'd1,
        RS   = 3'd2,
        RC   = 3'd3,
        RWI  = 3'd5,  // 3'd4 unused, decoded as illegal
        RSI  = 3'd6,
        RCI  = 3'd7
    } csr_op_e;

    // Target counter
    typedef enum logic [1:0] {
        SEL_CYCLE,
        SEL_TIME,
        SEL_INSTRET
    } csr_sel_e;

    localparam csr_addr_t CYCLE_ADDR    = 12'hC00;
    localparam csr_addr_t TIME_ADDR     = 12'hC01;
    localparam csr_addr_t INSTRET_ADDR  = 12'hC02;
    localparam csr_addr_t CYCLEH_ADDR   = 12'hC80;  // Upper halves
    localparam csr_addr_t TIMEH_ADDR    = 12'hC81;
    localparam csr_addr_t INSTRETH_ADDR = 12'hC82;

    localparam int CSR_UIMM_W = 5;  // zimm field width

    // Known encodings only
    function automatic logic op_legal(input csr_op_e op);
        return op inside {NONE, RW, RS, RC, RWI, RSI, RCI};
    endfunction

    // Immediate forms take the low bits, zero-extended
    function automatic csr_word_t op_operand(input csr_op_e op, input csr_word_t operand);
        return op[2] ? csr_word_t'(operand[CSR_UIMM_W-1:0]) : operand;
    endfunction

    // Set and clear with a zero source only read
    function automatic logic op_writes(input csr_op_e op, input csr_word_t src);
        case (op)
            RW, RWI:           return 1'b1;
            RS, RC, RSI, RCI:  return src != '0;
            default:           return 1'b0;
        endcase
    endfunction

    // New half-word from old value and source
    function automatic csr_word_t op_apply(input csr_op_e op, input csr_word_t old,
                                           input csr_word_t src);
        case (op)
            RW, RWI:   return src;
            RS, RSI:   return old | src;
            RC, RCI:   return old & ~src;
            default:   return old;
        endcase
    endfunction

endpackage
